// ==== Bender.yml ====
package:
  name: la_capture

sources:
  - hw/la_pkg.sv
  - hw/cmd_decoder.sv
  - hw/sample_cache.sv
  - hw/sample_ram.sv
  - hw/ctrl.sv
  - hw/byte_tx.sv
  - hw/la_top.sv
  - target: test
    files:
      - dv/la_checker.sv
      - dv/la_monitor.sv
      - dv/tb_la_top.sv

// ==== all.f ====
hw/la_pkg.sv
hw/cmd_decoder.sv
hw/sample_cache.sv
hw/sample_ram.sv
hw/ctrl.sv
hw/byte_tx.sv
hw/la_top.sv
dv/la_checker.sv
dv/la_monitor.sv
dv/tb_la_top.sv

// ==== dv/la_checker.sv ====
// handshake and capture enable assertions bound into every ctrl instance by the testbench
`default_nettype none
`timescale 1ns/1ps

module la_checker (
  input logic                clk_i,
  input logic                rst_in,
  input la_pkg::ctrl_state_e state_i,
  input logic                cen_i,
  input logic                tx_stb_i,
  input logic                tx_rdy_i,
  input logic [2:0]          tx_width_i
);

  int fail_cnt = 0;  // failed assertion count

  // a transfer start is a single-cycle strobe
  a_stb_pulse: assert property (@(posedge clk_i) disable iff (!rst_in) tx_stb_i |=> !tx_stb_i)
    else begin
      fail_cnt++;
      $error("tx_stb stayed high for more than one cycle");
    end

  a_stb_rdy: assert property (@(posedge clk_i) disable iff (!rst_in) tx_stb_i |-> tx_rdy_i)
    else begin
      fail_cnt++;
      $error("tx_stb raised while the transmitter was busy");
    end

  // no sampling while the ring is read back
  a_cen_off: assert property (@(posedge clk_i) disable iff (!rst_in)
      (state_i != la_pkg::IDLE && state_i != la_pkg::TRG) |-> !cen_i)
    else begin
      fail_cnt++;
      $error("capture enable high outside the sampling states");
    end

  a_width: assert property (@(posedge clk_i) disable iff (!rst_in) tx_width_i <= 3'd4)
    else begin
      fail_cnt++;
      $error("tx_width larger than one word");
    end

endmodule

`default_nettype wire

// ==== dv/la_monitor.sv ====
// reference model of command decode, byte packing and ring readback, compares the tx byte stream
`default_nettype none
`timescale 1ns/1ps

module la_monitor #(
  parameter int unsigned DEPTH = 5                 // ring address bits, same as the DUT
) (
  input  logic                      clk_i,
  input  logic                      rst_in,
  input  logic                      rx_stb_i,
  input  logic [7:0]                rx_data_i,
  input  logic [la_pkg::WIDTH-1:0]  sample_i,
  input  logic                      tx_valid_i,
  input  logic [7:0]                tx_data_i,
  input  logic [2:0]                exp_grp_i,     // active groups expected for this run
  output int                        done_cnt_o,    // readbacks fully received
  output int                        pending_o,     // bytes still expected
  output int                        mism_cnt_o,
  output int                        extra_cnt_o
);

  localparam int unsigned W = la_pkg::WIDTH;

  typedef enum logic [1:0] {M_IDLE, M_TRG, M_TX} phase_e;

  logic [W-1:0]     ring [2**DEPTH];
  logic [DEPTH-1:0] ptr;
  logic [7:0]       cache_q [$];   // packed bytes not yet in a word
  logic [7:0]       exp_q [$];     // predicted tx bytes
  logic [3:0]       cfg;
  logic [15:0]      rd_cnt, dly_cnt;
  logic [7:0]       op;
  logic [W-1:0]     data;
  logic             busy, run_pend;
  int               idx, post, hold, total;
  phase_e           st;

  always @(posedge clk_i) begin : model
    logic             run_now;
    logic             cstb;
    logic [W-1:0]     word;
    logic [DEPTH-1:0] rp;
    logic [7:0]       exp_b;
    if (!rst_in) begin
      st = M_IDLE;
      ptr = '0;
      cache_q.delete();
      exp_q.delete();
      cfg = 4'hf;                                    // all groups
      rd_cnt = '0;
      dly_cnt = '0;
      busy = 1'b0;
      run_pend = 1'b0;
      done_cnt_o = 0;
      mism_cnt_o = 0;
      extra_cnt_o = 0;
    end else begin
      if (tx_valid_i === 1'b1) begin
        if (exp_q.size() == 0) begin
          extra_cnt_o++;
          $display("unexpected byte %02h on tx_data_o at %0t, no readback pending",
                   tx_data_i, $time);
        end else begin
          exp_b = exp_q.pop_front();
          if (tx_data_i !== exp_b) begin
            mism_cnt_o++;
            $display("** Error at %0t: tx_data_o expected %02h, actual %02h",
                     $time, exp_b, tx_data_i);
          end
          if (exp_q.size() == 0) done_cnt_o++;
        end
      end
      run_now = run_pend;                            // run pulse is one clock late
      run_pend = 1'b0;
      case (st)
        M_IDLE, M_TRG: begin
          for (int g = 0; g < 4; g++) begin
            if (cfg[g]) cache_q.push_back(sample_i[8*g +: 8]);
          end
          cstb = (cache_q.size() >= 4);
          if (cstb) begin
            word = {cache_q[3], cache_q[2], cache_q[1], cache_q[0]};
            repeat (4) void'(cache_q.pop_front());
            ring[ptr] = word;
          end
          if (st == M_IDLE) begin
            if (cstb) ptr++;
            if (run_now) begin
              st = M_TRG;
              post = 0;
            end
          end else if (cstb) begin
            if (post == 4 * int'(dly_cnt) + 3) begin
              // last post-trigger word, predict cache bytes then words backwards
              total = ((exp_grp_i == 3'd0) ? 4 : int'(exp_grp_i)) * (int'(rd_cnt) + 2);
              exp_q.delete();
              foreach (cache_q[i]) exp_q.push_back(cache_q[i]);
              rp = ptr;
              for (int k = 0; k <= total; k++) begin
                for (int b = 0; b < 4; b++) exp_q.push_back(ring[rp][8*b +: 8]);
                rp = rp - 1'b1;
              end
              ptr = rp;
              hold = 3 + cache_q.size() + 6 * total;  // cache flush plus 6 clocks per word
              st = M_TX;
            end else begin
              post++;
              ptr++;
            end
          end
        end
        M_TX: begin
          hold--;
          if (hold == 0) st = M_IDLE;               // sampling resumes after the last strobe
        end
        default: st = M_IDLE;
      endcase
      if (rx_stb_i) begin                            // command decode, lsb first payload
        if (!busy) begin
          op = rx_data_i;
          if (rx_data_i[7]) begin
            busy = 1'b1;
            idx = 0;
          end else if (rx_data_i == la_pkg::OP_RESET) begin
            cfg = 4'hf;
          end else if (rx_data_i == la_pkg::OP_RUN) begin
            run_pend = 1'b1;
          end
        end else begin
          data = {rx_data_i, data[W-1:8]};
          idx++;
          if (idx == 4) begin
            busy = 1'b0;
            if (op == la_pkg::OP_SET_CNT) begin
              rd_cnt = data[15:0];
              dly_cnt = data[31:16];
            end else if (op == la_pkg::OP_SET_CFG) begin
              cfg = data[3:0];
            end
          end
        end
      end
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== dv/tb_la_top.sv ====
// top testbench of the capture core, applies a table of configs and runs and sums the errors
`default_nettype none
`timescale 1ns/1ps

module tb_la_top;

  localparam int unsigned DEPTH = 5;
  localparam int          N_RUNS = 6;

  typedef struct packed {
    logic        use_rst;  // OP_RESET instead of OP_SET_CFG
    logic [3:0]  cfg;      // groups after the config command
    logic [15:0] rd;
    logic [15:0] dly;
    logic [7:0]  pre;      // sampling clocks before run
    logic [2:0]  grp;      // expected active groups
  } run_t;

  localparam run_t RUNS [N_RUNS] = '{
    '{1'b0, 4'hf, 16'd2, 16'd1, 8'd40, 3'd4},   // fills the whole ring first
    '{1'b0, 4'h1, 16'd1, 16'd0, 8'd30, 3'd1},
    '{1'b0, 4'h5, 16'd0, 16'd1, 8'd20, 3'd2},
    '{1'b0, 4'hb, 16'd1, 16'd0, 8'd25, 3'd3},
    '{1'b0, 4'he, 16'd3, 16'd0, 8'd17, 3'd3},   // leaves a partial cache word
    '{1'b1, 4'hf, 16'd0, 16'd0, 8'd9,  3'd4}
  };

  logic                     clk_i = 1'b0;
  logic                     rst_in, rx_stb_i;
  logic [7:0]               rx_data_i, tx_data_o;
  logic [la_pkg::WIDTH-1:0] sample_i;
  logic                     tx_valid_o;
  logic [2:0]               exp_grp;
  int                       done_cnt, pending, mism_cnt, extra_cnt;
  int                       missing = 0;

  always #5 clk_i = ~clk_i;

  la_top #(.DEPTH(DEPTH)) uut (
    .clk_i, .rst_in, .rx_stb_i, .rx_data_i, .sample_i, .tx_valid_o, .tx_data_o
  );

  la_monitor #(.DEPTH(DEPTH)) mon (
    .clk_i, .rst_in, .rx_stb_i, .rx_data_i, .sample_i, .tx_valid_i(tx_valid_o),
    .tx_data_i(tx_data_o), .exp_grp_i(exp_grp), .done_cnt_o(done_cnt),
    .pending_o(pending), .mism_cnt_o(mism_cnt), .extra_cnt_o(extra_cnt)
  );

  bind ctrl la_checker u_chk (
    .clk_i, .rst_in, .state_i(state), .cen_i(cen_o), .tx_stb_i(tx_stb_o),
    .tx_rdy_i, .tx_width_i(tx_width_o)
  );

  // post-run bound, capture at one byte per clock plus 6 clocks per word sent
  function automatic int run_cycles(input run_t r);
    int total;
    total = (r.rd + 2) * r.grp;
    return 16 * (r.dly + 1) + 6 * (total + 1) + 20;
  endfunction

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk_i);
    rx_stb_i  = 1'b1;
    rx_data_i = b;
    @(negedge clk_i);
    rx_stb_i  = 1'b0;
  endtask

  task automatic send_long(input logic [7:0] op, input logic [31:0] word);
    send_byte(op);
    for (int i = 0; i < 4; i++) send_byte(word[8*i +: 8]);   // lsb first
  endtask

  initial begin : sample_gen
    sample_i = $urandom(68838);   // seeds this process
    forever begin
      @(negedge clk_i);
      sample_i = $urandom;
    end
  end

  initial begin : watchdog
    int limit;
    limit = 10;
    foreach (RUNS[i]) limit += 40 + RUNS[i].pre + run_cycles(RUNS[i]);
    #(limit * 20);                // 10 ns clock, twice the expected length
    $display("timeout: readback did not finish within %0d ns", limit * 20);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    int waited;
    int asrt;
    rst_in    = 1'b0;
    rx_stb_i  = 1'b0;
    rx_data_i = 8'h00;
    exp_grp   = 3'd4;
    repeat (3) @(negedge clk_i);
    rst_in = 1'b1;
    for (int i = 0; i < N_RUNS; i++) begin
      if (RUNS[i].use_rst) begin
        send_byte(la_pkg::OP_RESET);
      end else begin
        send_long(la_pkg::OP_SET_CFG, {28'd0, RUNS[i].cfg});
      end
      send_long(la_pkg::OP_SET_CNT, {RUNS[i].dly, RUNS[i].rd});
      exp_grp = RUNS[i].grp;
      repeat (RUNS[i].pre) @(negedge clk_i);
      send_byte(la_pkg::OP_RUN);
      waited = 0;
      while (done_cnt <= i && waited < run_cycles(RUNS[i])) begin
        @(negedge clk_i);
        waited++;
      end
      if (done_cnt <= i) begin
        missing++;
        $display("run %0d ended with %0d expected bytes never sent", i, pending);
      end
      repeat (8) @(negedge clk_i);  // window for extra bytes
    end
    asrt = uut.u_ctrl.u_chk.fail_cnt;
    $display("errors: mismatch %0d, extra %0d, missing %0d, assertion %0d",
             mism_cnt, extra_cnt, missing, asrt);
    if (mism_cnt + extra_cnt + missing + asrt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/byte_tx.sv ====
// byte transmitter, latches a cache or memory word and sends it lsb first, one byte per clock
`default_nettype none
`timescale 1ns/1ps

module byte_tx (
  input  logic                      clk_i,
  input  logic                      rst_in,        // sync, active low
  input  logic                      tx_stb_i,      // latch a word and start
  input  logic                      sel_cache_i,   // take the cache word
  input  logic [2:0]                width_i,       // bytes to send, 0 to 4
  input  logic [la_pkg::WIDTH-1:0]  cache_word_i,
  input  logic [la_pkg::WIDTH-1:0]  mem_word_i,
  output logic                      tx_rdy_o,      // no bytes left
  output logic                      tx_valid_o,    // byte on tx_data_o
  output logic [7:0]                tx_data_o
);

  logic [la_pkg::WIDTH-1:0] shift_q;  // bytes still to go, lowest next
  logic [2:0]               left_q;   // remaining byte count

  assign tx_valid_o = (left_q != 3'd0);
  assign tx_rdy_o   = (left_q == 3'd0);
  assign tx_data_o  = shift_q[7:0];

  always_ff @(posedge clk_i) begin : byte_cnt
    if (!rst_in) begin
      left_q <= 3'd0;
    end else if (tx_stb_i) begin
      left_q <= width_i;                  // width 0 leaves rdy high
    end else if (left_q != 3'd0) begin
      left_q <= left_q - 3'd1;
    end
  end

  // word shift register
  always_ff @(posedge clk_i) begin : shifter
    if (tx_stb_i) begin
      if (sel_cache_i) begin
        shift_q <= cache_word_i;
      end else begin
        shift_q <= mem_word_i;
      end
    end else if (left_q != 3'd0) begin
      shift_q <= shift_q >> 8;            // next byte down
    end
  end

endmodule

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
// byte-wide command receiver, turns short and long commands into pulses and channel config
`default_nettype none
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                      clk_i,
  input  logic                      rst_in,      // sync, active low
  input  logic                      rx_stb_i,    // one command byte per strobe
  input  logic [7:0]                rx_data_i,
  output logic                      run_o,       // pulse, arm trigger
  output logic                      set_cnt_o,   // pulse, cmd_o holds the counts
  output logic [la_pkg::WIDTH-1:0]  cmd_o,       // data word of the last long command
  output logic [3:0]                cfg_o        // active channel groups
);

  localparam int unsigned W = la_pkg::WIDTH;

  la_pkg::opcode_e op_q;   // opcode of the long command in progress
  logic            busy_q; // collecting data bytes
  logic [1:0]      idx_q;  // data byte index
  logic [W-1:0]    cmd_q;
  logic [W-1:0]    cmd_next;

  // data bytes arrive lsb first, so shift in from the top
  assign cmd_next = {rx_data_i, cmd_q[W-1:8]};
  assign cmd_o    = cmd_q;

  always_ff @(posedge clk_i) begin : decode
    if (!rst_in) begin
      op_q      <= la_pkg::OP_RESET;
      busy_q    <= 1'b0;
      idx_q     <= 2'd0;
      run_o     <= 1'b0;
      set_cnt_o <= 1'b0;
      cfg_o     <= 4'hf;                       // all groups after reset
    end else begin
      run_o     <= 1'b0;                       // pulses last one clock
      set_cnt_o <= 1'b0;
      if (rx_stb_i) begin
        if (!busy_q) begin
          op_q <= la_pkg::opcode_e'(rx_data_i);
          if (rx_data_i[7]) begin              // long command, four bytes to come
            busy_q <= 1'b1;
            idx_q  <= 2'd0;
          end else begin
            case (rx_data_i)
              la_pkg::OP_RESET: cfg_o <= 4'hf;
              la_pkg::OP_RUN:   run_o <= 1'b1;
              default: ;                       // unknown short opcode
            endcase
          end
        end else begin
          idx_q <= idx_q + 2'd1;
          if (idx_q == 2'd3) begin             // fifth byte of the command
            busy_q <= 1'b0;
            case (op_q)
              la_pkg::OP_SET_CNT: set_cnt_o <= 1'b1;
              la_pkg::OP_SET_CFG: cfg_o     <= cmd_next[3:0];
              default: ;                       // unknown long opcode, bytes dropped
            endcase
          end
        end
      end
    end
  end

  // payload shift register
  always_ff @(posedge clk_i) begin : data_shift
    if (rx_stb_i && busy_q) cmd_q <= cmd_next;
  end

endmodule

`default_nettype wire

// ==== hw/ctrl.sv ====
// capture controller FSM, samples into the ring, counts post-trigger words and reads back
`default_nettype none
`timescale 1ns/1ps

module ctrl #(
  parameter int unsigned DEPTH = 5                   // ring address bits
) (
  input  logic                      clk_i,
  input  logic                      rst_in,          // sync, active low
  input  logic                      set_cnt_i,       // load read and delay counts
  input  logic [la_pkg::WIDTH-1:0]  cmd_i,           // command data word
  input  logic                      run_i,           // trigger
  input  logic                      cstb_i,          // cache word written to the ring
  input  logic [3:0]                cfg_i,           // active channel groups
  output logic                      cen_o,           // capture enable
  output logic [DEPTH-1:0]          addr_o,          // ring pointer
  input  logic                      tx_rdy_i,        // transmitter idle
  output logic                      tx_stb_o,        // start one transfer
  output logic                      tx_sel_cache_o,  // send the cache word, else memory
  output logic [2:0]                tx_width_o       // bytes in this transfer
);

  localparam int unsigned CW = la_pkg::CNT_WIDTH;

  la_pkg::ctrl_state_e state, state_next;

  logic [CW-1:0]   rd_cnt;            // readback count from the host
  logic [CW-1:0]   dly_cnt;           // post-trigger count from the host
  logic [CW+3:0]   cnt, cnt_next;     // post-trigger words, then words sent
  logic [DEPTH-1:0] ptr, ptr_next;    // ring pointer
  logic [1:0]      c_cnt, c_cnt_next; // bytes sitting in the cache
  logic [2:0]      cfg_ones;          // number of active groups
  logic [CW+3:0]   rd_ext;            // rd_cnt + 2, widened
  logic [CW+3:0]   rd_mem_cnt;        // last value of cnt in TX

  assign addr_o         = ptr;
  assign tx_sel_cache_o = (state == la_pkg::TX_CACHE);

  always_comb begin : count_groups
    cfg_ones = 3'd0;
    for (int g = 0; g < 4; g++) cfg_ones = cfg_ones + {2'b00, cfg_i[g]};
  end

  // readback length scales with the groups, a few extra words may go out
  assign rd_ext = {4'b0000, rd_cnt} + 2'd2;
  always_comb begin : readback_len
    case (cfg_ones)
      3'd1:    rd_mem_cnt = rd_ext;
      3'd2:    rd_mem_cnt = rd_ext << 1;
      3'd3:    rd_mem_cnt = rd_ext + (rd_ext << 1);
      default: rd_mem_cnt = rd_ext << 2;   // four groups, or none
    endcase
  end

  always_comb begin : main_fsm
    state_next = state;
    cnt_next   = cnt;
    ptr_next   = ptr;
    c_cnt_next = c_cnt;
    cen_o      = 1'b0;
    tx_stb_o   = 1'b0;
    tx_width_o = 3'd4;                      // full memory word
    case (state)
      la_pkg::IDLE: begin                   // keep a pre-trigger history
        cen_o      = 1'b1;
        c_cnt_next = 2'(c_cnt + cfg_ones);  // mirrors the cache fill count
        if (cstb_i) ptr_next = ptr + 1'b1;
        if (run_i) begin
          state_next = la_pkg::TRG;
          cnt_next   = '0;
        end
      end
      la_pkg::TRG: begin
        cen_o      = 1'b1;
        c_cnt_next = 2'(c_cnt + cfg_ones);
        if (cstb_i) begin
          if (cnt == {2'b00, dly_cnt, 2'b11}) begin
            // word 4*dly+4 goes to ptr, which stays on the last write
            state_next = la_pkg::TX_CACHE;
            cnt_next   = '0;
          end else begin
            cnt_next = cnt + 1'b1;
            ptr_next = ptr + 1'b1;
          end
        end
      end
      la_pkg::TX_CACHE: begin               // flush the partial word first
        tx_stb_o   = 1'b1;
        tx_width_o = {1'b0, c_cnt};         // zero fill sends nothing
        state_next = la_pkg::TX_WAIT;
      end
      la_pkg::TX: begin                     // one word backwards per visit
        tx_stb_o   = 1'b1;
        cnt_next   = cnt + 1'b1;
        ptr_next   = ptr - 1'b1;
        if (cnt == rd_mem_cnt) begin
          state_next = la_pkg::IDLE;
        end else begin
          state_next = la_pkg::TX_WAIT;
        end
      end
      la_pkg::TX_WAIT: begin
        if (tx_rdy_i) state_next = la_pkg::TX;
      end
      default: state_next = la_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin : fsm_regs
    if (!rst_in) begin
      state <= la_pkg::IDLE;
      cnt   <= '0;
      ptr   <= '0;
      c_cnt <= 2'd0;
    end else begin
      state <= state_next;
      cnt   <= cnt_next;
      ptr   <= ptr_next;
      c_cnt <= c_cnt_next;
    end
  end

  always_ff @(posedge clk_i) begin : count_regs
    if (!rst_in) begin
      rd_cnt  <= '0;
      dly_cnt <= '0;
    end else if (set_cnt_i) begin
      rd_cnt  <= cmd_i[CW-1:0];               // low half
      dly_cnt <= cmd_i[la_pkg::WIDTH-1:CW];   // high half
    end
  end

endmodule

`default_nettype wire

// ==== hw/la_pkg.sv ====
// shared widths, command opcodes and controller states of the logic analyzer core
`default_nettype none

package la_pkg;

  localparam int unsigned WIDTH     = 32;         // sample and memory word width
  localparam int unsigned CNT_WIDTH = WIDTH / 2;  // read and delay count width

  // command opcodes, bit 7 set means four data bytes follow
  typedef enum logic [7:0] {
    OP_RESET   = 8'h00,  // restore all channel groups
    OP_RUN     = 8'h01,  // arm trigger, here it fires at once
    OP_SET_CNT = 8'h81,  // read count low half, delay count high half
    OP_SET_CFG = 8'h82   // active channel groups in bits 3..0
  } opcode_e;

  // capture controller states
  typedef enum logic [2:0] {
    IDLE,      // pre-trigger sampling into the ring
    TRG,       // post-trigger sampling
    TX,        // send one memory word
    TX_CACHE,  // send the partial cache word
    TX_WAIT    // wait for the byte transmitter
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hw/la_top.sv ====
// logic analyzer capture core top level, joins decoder, cache, ring RAM, controller and transmitter
`default_nettype none
`timescale 1ns/1ps

module la_top #(
  parameter int unsigned DEPTH = 5                   // ring address bits
) (
  input  logic                      clk_i,
  input  logic                      rst_in,          // sync, active low
  input  logic                      rx_stb_i,        // command byte strobe
  input  logic [7:0]                rx_data_i,
  input  logic [la_pkg::WIDTH-1:0]  sample_i,        // taken every clock
  output logic                      tx_valid_o,
  output logic [7:0]                tx_data_o
);

  logic                     run, set_cnt, cen, cstb;
  logic [la_pkg::WIDTH-1:0] cmd;
  logic [3:0]               cfg;
  logic [la_pkg::WIDTH-1:0] cache_word, full_word, rd_word;
  logic [DEPTH-1:0]         addr;
  logic                     tx_stb, tx_sel_cache, tx_rdy;
  logic [2:0]               tx_width;

  cmd_decoder u_dec (
    .clk_i, .rst_in, .rx_stb_i, .rx_data_i,
    .run_o(run), .set_cnt_o(set_cnt), .cmd_o(cmd), .cfg_o(cfg)
  );

  sample_cache u_cache (
    .clk_i, .rst_in, .cen_i(cen), .cfg_i(cfg), .sample_i,
    .cstb_o(cstb), .full_word_o(full_word), .cache_word_o(cache_word)
  );

  sample_ram #(.DEPTH(DEPTH)) u_ram (
    .clk_i, .we_i(cen & cstb), .addr_i(addr), .wdata_i(full_word), .rdata_o(rd_word)
  );

  ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk_i, .rst_in, .set_cnt_i(set_cnt), .cmd_i(cmd), .run_i(run), .cstb_i(cstb),
    .cfg_i(cfg), .cen_o(cen), .addr_o(addr), .tx_rdy_i(tx_rdy), .tx_stb_o(tx_stb),
    .tx_sel_cache_o(tx_sel_cache), .tx_width_o(tx_width)
  );

  byte_tx u_tx (
    .clk_i, .rst_in, .tx_stb_i(tx_stb), .sel_cache_i(tx_sel_cache), .width_i(tx_width),
    .cache_word_i(cache_word), .mem_word_i(rd_word), .tx_rdy_o(tx_rdy),
    .tx_valid_o, .tx_data_o
  );

endmodule

`default_nettype wire

// ==== hw/sample_cache.sv ====
// packs the bytes of the active channel groups of each sample into 32-bit memory words
`default_nettype none
`timescale 1ns/1ps

module sample_cache (
  input  logic                      clk_i,
  input  logic                      rst_in,        // sync, active low
  input  logic                      cen_i,         // capture enable
  input  logic [3:0]                cfg_i,         // active channel groups
  input  logic [la_pkg::WIDTH-1:0]  sample_i,      // one sample per clock
  output logic                      cstb_o,        // word completed this cycle
  output logic [la_pkg::WIDTH-1:0]  full_word_o,   // completed word, valid with cstb_o
  output logic [la_pkg::WIDTH-1:0]  cache_word_o   // incomplete word for the final flush
);

  localparam int unsigned W = la_pkg::WIDTH;

  logic [1:0]     fill_q;    // bytes held in part_q
  logic [W-1:0]   part_q;    // partial word, low fill_q bytes valid
  logic [2*W-1:0] lane_buf;  // partial word plus appended lanes
  logic [2:0]     pos;       // byte count after appending

  // append active lanes behind the cached bytes, group 0 first
  always_comb begin : pack
    lane_buf = {{W{1'b0}}, part_q};
    pos      = {1'b0, fill_q};
    for (int g = 0; g < 4; g++) begin
      if (cfg_i[g]) begin
        lane_buf[{pos, 3'b000} +: 8] = sample_i[g*8 +: 8];
        pos = pos + 3'd1;
      end
    end
  end

  assign cstb_o       = cen_i & pos[2];      // byte count wrapped past four
  assign full_word_o  = lane_buf[W-1:0];
  assign cache_word_o = part_q;

  always_ff @(posedge clk_i) begin : fill_cnt
    if (!rst_in) begin
      fill_q <= 2'd0;
    end else if (cen_i) begin
      fill_q <= pos[1:0];                    // leftover bytes start the next word
    end
  end

  // bytes of the word being filled, only the low fill_q are meaningful
  always_ff @(posedge clk_i) begin : part_word
    if (cen_i) begin
      if (pos[2]) begin
        part_q <= lane_buf[2*W-1:W];         // spill into the next word
      end else begin
        part_q <= lane_buf[W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/sample_ram.sv ====
// capture ring buffer of 2^DEPTH words, written by the cache and read back by the controller
`default_nettype none
`timescale 1ns/1ps

module sample_ram #(
  parameter int unsigned DEPTH = 5           // address bits
) (
  input  logic                      clk_i,
  input  logic                      we_i,    // capture enable and word strobe
  input  logic [DEPTH-1:0]          addr_i,  // ring pointer from ctrl
  input  logic [la_pkg::WIDTH-1:0]  wdata_i,
  output logic [la_pkg::WIDTH-1:0]  rdata_o  // combinational read
);

  logic [la_pkg::WIDTH-1:0] mem [2**DEPTH];

  // sync write at the pointer
  always_ff @(posedge clk_i) begin : wr_port
    if (we_i) mem[addr_i] <= wdata_i;
  end

  // async read, byte_tx latches it in the TX cycle
  assign rdata_o = mem[addr_i];

endmodule

`default_nettype wire
